/* include/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// reset vector of the core, start of the boot ROM
`define FETCH_BOOT_PC 32'hbfc00000

// branch prediction buffer entries
// must be a power of two, index comes from pc word bits
`define FETCH_BPB_DEPTH 16

`endif

/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] word_t;

    // one prediction from the target buffer
    typedef struct packed {
        logic  taken;
        word_t destpc;
    } bpb_result_t;

    // one fetched instruction handed to decode
    typedef struct packed {
        word_t       instr;
        word_t       pcplus4;
        logic        en;
        // pc not word aligned
        logic        exception_instr;
        bpb_result_t pred;
    } fetch_data_t;

endpackage

`default_nettype wire

/* rtl/fetch_redirect_select.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_redirect_select (
    input  wire logic              exception_valid,
    input  wire logic              is_eret,
    input  wire logic              branch,
    input  wire logic              jump,
    input  wire logic              jr,
    input  wire fetch_pkg::word_t  pcexception,
    input  wire fetch_pkg::word_t  epc,
    input  wire fetch_pkg::word_t  pcbranch,
    input  wire fetch_pkg::word_t  pcjump,
    input  wire fetch_pkg::word_t  pcjr,
    input  wire fetch_pkg::word_t  pc_seq,
    output fetch_pkg::word_t       pc_new,
    output logic                   pc_upd
);

    // exception first, then eret, then the resolved control flow
    always_comb
    begin
        if (exception_valid)
        begin
            pc_new = pcexception;
        end
        else if (is_eret)
        begin
            pc_new = epc;
        end
        else if (branch)
        begin
            pc_new = pcbranch;
        end
        else if (jump)
        begin
            pc_new = pcjump;
        end
        else if (jr)
        begin
            pc_new = pcjr;
        end
        else
        begin
            // no redirect, follow the fetch side guess
            pc_new = pc_seq;
        end
    end

    assign pc_upd = exception_valid | is_eret | branch | jump | jr;

endmodule

`default_nettype wire

/* rtl/branch_predict_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module branch_predict_buffer (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire fetch_pkg::word_t       rd_pc0,
    input  wire fetch_pkg::word_t       rd_pc1,
    output fetch_pkg::bpb_result_t      rd_result0,
    output fetch_pkg::bpb_result_t      rd_result1,
    input  wire logic                   upd_valid,
    input  wire fetch_pkg::word_t       upd_pc,
    input  wire logic                   upd_taken,
    input  wire fetch_pkg::word_t       upd_target
);

    localparam int DEPTH = `FETCH_BPB_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int TAG_W = 32 - IDX_W - 2;

    logic [DEPTH-1:0]       valid;
    logic [TAG_W-1:0]       tag_mem [DEPTH];
    fetch_pkg::bpb_result_t res_mem [DEPTH];

    logic [IDX_W-1:0]       upd_idx;

    fetch_pkg::word_t       rd_pc     [2];
    fetch_pkg::bpb_result_t rd_result [2];

    assign rd_pc[0]   = rd_pc0;
    assign rd_pc[1]   = rd_pc1;
    assign rd_result0 = rd_result[0];
    assign rd_result1 = rd_result[1];

    // word index, byte offset bits ignored
    assign upd_idx = upd_pc[IDX_W+1:2];

    // both read ports are the same lookup
    for (genvar i = 0; i < 2; i++)
    begin : g_rd
        logic [IDX_W-1:0] idx;
        logic [TAG_W-1:0] tag;
        logic             hit;

        assign idx = rd_pc[i][IDX_W+1:2];
        assign tag = rd_pc[i][31:IDX_W+2];
        assign hit = valid[idx] && (tag_mem[idx] == tag);

        // miss reads as not taken
        assign rd_result[i] = hit ? res_mem[idx] : '0;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            valid <= '0;
        end
        else if (upd_valid)
        begin
            valid[upd_idx] <= 1'b1;
        end
    end

    // resolved branch overwrites the whole entry
    always_ff @(posedge clk)
    begin
        if (upd_valid)
        begin
            tag_mem[upd_idx]        <= upd_pc[31:IDX_W+2];
            res_mem[upd_idx].taken  <= upd_taken;
            res_mem[upd_idx].destpc <= upd_target;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_unit (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   flush,
    input  wire logic                   stall,
    input  wire logic                   pc_upd,
    input  wire fetch_pkg::word_t       pc_new,
    output fetch_pkg::word_t            pc_seq,
    output fetch_pkg::word_t            pc,
    output fetch_pkg::word_t            inst_addr,
    input  wire logic                   inst_data_ok,
    input  wire logic [63:0]            inst_data,
    input  wire logic                   inst_index,
    input  wire fetch_pkg::bpb_result_t pred0,
    input  wire fetch_pkg::bpb_result_t pred1,
    output fetch_pkg::word_t            pc_plus4,
    output fetch_pkg::fetch_data_t      slot0,
    output fetch_pkg::fetch_data_t      slot1,
    output logic [1:0]                  slot_hit,
    output logic                        finish
);

    fetch_pkg::bpb_result_t last_predict;
    fetch_pkg::bpb_result_t next_predict;
    fetch_pkg::word_t       pc_plus8;
    logic                   conflict;
    logic                   slot0_en;
    logic                   exception_instr;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            pc           <= `FETCH_BOOT_PC;
            last_predict <= '0;
        end
        else if (flush)
        begin
            pc <= '0;
        end
        else if ((!stall && !conflict) || pc_upd)
        begin
            pc           <= pc_new;
            // a redirect invalidates whatever we guessed
            last_predict <= pc_upd ? '0 : next_predict;
        end
    end

    // one reply is still in flight after a redirect, drop it
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            conflict <= 1'b0;
        end
        else if (pc_upd)
        begin
            conflict <= 1'b1;
        end
        else if (inst_data_ok)
        begin
            conflict <= 1'b0;
        end
    end

    assign inst_addr       = pc;
    assign pc_plus4        = pc + 32'd4;
    assign pc_plus8        = pc + 32'd8;
    assign exception_instr = (pc[1:0] != 2'b00);
    assign finish          = inst_data_ok && !conflict;

    // second word only when the pair is aligned and no taken branch is pending
    assign slot0_en = !inst_index && !last_predict.taken;
    assign slot_hit = {1'b1, slot0_en};

    // slot 1 is the word at pc
    assign slot1.instr           = inst_index ? inst_data[63:32] : inst_data[31:0];
    assign slot1.pcplus4         = pc_plus4;
    assign slot1.en              = 1'b1;
    assign slot1.exception_instr = exception_instr;
    assign slot1.pred            = pred1;

    // slot 0 is the word at pc+4
    assign slot0.instr           = inst_index ? '0 : inst_data[63:32];
    assign slot0.pcplus4         = pc_plus8;
    assign slot0.en              = slot0_en;
    assign slot0.exception_instr = exception_instr;
    assign slot0.pred            = slot0_en ? pred0 : '0;

    // keep the prediction of the youngest fetched slot
    assign next_predict = slot0_en ? pred0 : pred1;

    always_comb
    begin
        if (last_predict.taken)
        begin
            // delay slot already fetched, go to target
            pc_seq = last_predict.destpc;
        end
        else if (pred1.taken && slot0_en)
        begin
            pc_seq = pred1.destpc;
        end
        else if (slot0_en)
        begin
            pc_seq = pc_plus8;
        end
        else
        begin
            pc_seq = pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   flush,
    input  wire logic                   stall,
    input  wire logic                   exception_valid,
    input  wire logic                   is_eret,
    input  wire logic                   branch,
    input  wire logic                   jump,
    input  wire logic                   jr,
    input  wire fetch_pkg::word_t       pcexception,
    input  wire fetch_pkg::word_t       epc,
    input  wire fetch_pkg::word_t       pcbranch,
    input  wire fetch_pkg::word_t       pcjump,
    input  wire fetch_pkg::word_t       pcjr,
    input  wire logic                   upd_valid,
    input  wire fetch_pkg::word_t       upd_pc,
    input  wire logic                   upd_taken,
    input  wire fetch_pkg::word_t       upd_target,
    output fetch_pkg::word_t            inst_addr,
    input  wire logic                   inst_data_ok,
    input  wire logic [63:0]            inst_data,
    input  wire logic                   inst_index,
    output fetch_pkg::fetch_data_t      slot0,
    output fetch_pkg::fetch_data_t      slot1,
    output logic [1:0]                  slot_hit,
    output logic                        finish,
    output fetch_pkg::word_t            pc
);

    fetch_pkg::word_t       pc_new;
    fetch_pkg::word_t       pc_seq;
    fetch_pkg::word_t       pc_plus4;
    logic                   pc_upd;
    fetch_pkg::bpb_result_t pred0;
    fetch_pkg::bpb_result_t pred1;

    fetch_unit u_fetch_unit (
        .clk(clk), .reset(reset), .flush(flush), .stall(stall),
        .pc_upd(pc_upd), .pc_new(pc_new), .pc_seq(pc_seq), .pc(pc),
        .inst_addr(inst_addr), .inst_data_ok(inst_data_ok),
        .inst_data(inst_data), .inst_index(inst_index),
        .pred0(pred0), .pred1(pred1), .pc_plus4(pc_plus4),
        .slot0(slot0), .slot1(slot1), .slot_hit(slot_hit), .finish(finish)
    );

    fetch_redirect_select u_redirect (
        .exception_valid(exception_valid), .is_eret(is_eret),
        .branch(branch), .jump(jump), .jr(jr),
        .pcexception(pcexception), .epc(epc), .pcbranch(pcbranch),
        .pcjump(pcjump), .pcjr(pcjr), .pc_seq(pc_seq),
        .pc_new(pc_new), .pc_upd(pc_upd)
    );

    // port 0 looks up pc+4 for slot 0, port 1 looks up pc for slot 1
    branch_predict_buffer u_bpb (
        .clk(clk), .reset(reset),
        .rd_pc0(pc_plus4), .rd_pc1(pc),
        .rd_result0(pred0), .rd_result1(pred1),
        .upd_valid(upd_valid), .upd_pc(upd_pc),
        .upd_taken(upd_taken), .upd_target(upd_target)
    );

endmodule

`default_nettype wire

/* dv/fetch_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_assertions (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   flush,
    input  wire logic                   stall,
    input  wire logic                   pc_upd,
    input  wire fetch_pkg::word_t       pc,
    input  wire logic                   conflict,
    input  wire logic                   finish,
    input  wire fetch_pkg::fetch_data_t slot0
);

    // stalled fetch with no redirect keeps its address
    pc_hold: assert property (@(posedge clk) disable iff (reset)
        (stall && !pc_upd && !flush) |=> $stable(pc))
        else $error("pc moved while stalled without redirect or flush");

    // the stale reply after a redirect must not reach decode
    no_finish_after_redirect: assert property (@(posedge clk) disable iff (reset)
        pc_upd |=> !finish)
        else $error("finish raised in the cycle after a redirect");

    // a taken branch in slot 0 is followed by its delay slot alone
    slot0_off_after_taken: assert property (@(posedge clk) disable iff (reset)
        (slot0.en && slot0.pred.taken && !stall && !conflict && !pc_upd && !flush)
            |=> !slot0.en)
        else $error("slot 0 enabled right after a taken slot 0 prediction");

endmodule

`default_nettype wire

/* dv/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_tb;

    localparam int RUN_CYCLES = 2000;
    // run length plus a quarter of headroom
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;
    localparam int IDX_W = $clog2(`FETCH_BPB_DEPTH);

    logic clk, reset, flush, stall, inst_data_ok, inst_index, finish;
    logic exception_valid, is_eret, branch, jump, jr, upd_valid, upd_taken;
    fetch_pkg::word_t pcexception, epc, pcbranch, pcjump, pcjr, upd_pc, upd_target;
    fetch_pkg::word_t inst_addr, pc;
    logic [63:0] inst_data;
    logic [1:0] slot_hit;
    fetch_pkg::fetch_data_t slot0, slot1;

    // reference model state
    fetch_pkg::word_t m_pc;
    logic m_conflict;
    fetch_pkg::bpb_result_t m_last;
    logic [`FETCH_BPB_DEPTH-1:0] m_valid;
    fetch_pkg::word_t m_upd_pc [`FETCH_BPB_DEPTH];
    fetch_pkg::bpb_result_t m_entry [`FETCH_BPB_DEPTH];
    logic [15:0] lfsr;
    int errors;
    int cycle_count = 0;

    fetch_top dut (.*);

    bind fetch_unit fetch_assertions u_assertions (.clk(clk), .reset(reset), .flush(flush),
        .stall(stall), .pc_upd(pc_upd), .pc(pc), .conflict(conflict), .finish(finish),
        .slot0(slot0));

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // instruction word stored at a byte address
    function automatic fetch_pkg::word_t mem_word(input fetch_pkg::word_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'd40503) ^ 32'h3c1ae5d7;
    endfunction

    // near the boot vector so buffer tags collide often, rarely unaligned
    task automatic rand_addr(output fetch_pkg::word_t a);
        logic [31:0] r;
        take_bits(12, r);
        a = `FETCH_BOOT_PC + {22'd0, r[7:0], 2'b00};
        if (r[11:8] == 4'd0)
            a[1:0] = 2'b10;
    endtask

    function automatic fetch_pkg::bpb_result_t predict(input fetch_pkg::word_t a);
        logic [IDX_W-1:0] idx;
        idx = a[IDX_W+1:2];
        if (m_valid[idx] && m_upd_pc[idx][31:IDX_W+2] == a[31:IDX_W+2])
            return m_entry[idx];
        return '0;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("error %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        fetch_pkg::word_t base;
        take_bits(20, r);
        inst_data_ok = r[0];
        // no reply means stall, plus some extra stalls
        stall = !r[0] || (r[3:1] == 3'd0);
        flush = (r[9:4] == 6'd0);
        upd_valid = (r[11:10] == 2'd0);
        upd_taken = r[12];
        if (upd_valid)
        begin
            rand_addr(upd_pc);
            rand_addr(upd_target);
        end
        {exception_valid, is_eret, branch, jump, jr} = '0;
        if (r[19:16] == 4'd0)
        begin
            // several sources at once exercise the priority
            take_bits(5, r);
            {exception_valid, is_eret, branch, jump, jr} = r[4:0];
            rand_addr(pcexception);
            rand_addr(epc);
            rand_addr(pcbranch);
            rand_addr(pcjump);
            rand_addr(pcjr);
        end
        // memory answers with the aligned doubleword
        base = {inst_addr[31:3], 3'b000};
        inst_index = inst_addr[2];
        inst_data = {mem_word(base + 32'd4), mem_word(base)};
    endtask

    initial
    begin
        fetch_pkg::bpb_result_t p0;
        fetch_pkg::bpb_result_t p1;
        fetch_pkg::word_t seq_pc;
        fetch_pkg::word_t new_pc;
        logic s0_en;
        logic redirect;

        lfsr = 16'd25;
        errors = 0;
        reset = 1'b1;
        {flush, stall, inst_data_ok, inst_index, upd_valid, upd_taken} = '0;
        {exception_valid, is_eret, branch, jump, jr} = '0;
        {pcexception, epc, pcbranch, pcjump, pcjr, upd_pc, upd_target} = '0;
        inst_data = '0;
        m_pc = `FETCH_BOOT_PC;
        m_conflict = 1'b0;
        m_last = '0;
        m_valid = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int cyc = 0; cyc < RUN_CYCLES; cyc++)
        begin
            drive_inputs();
            p1 = predict(m_pc);
            p0 = predict(m_pc + 32'd4);
            s0_en = !m_pc[2] && !m_last.taken;
            if (m_last.taken)
                seq_pc = m_last.destpc;
            else if (p1.taken && s0_en)
                seq_pc = p1.destpc;
            else if (s0_en)
                seq_pc = m_pc + 32'd8;
            else
                seq_pc = m_pc + 32'd4;
            redirect = exception_valid | is_eret | branch | jump | jr;
            if (exception_valid)
                new_pc = pcexception;
            else if (is_eret)
                new_pc = epc;
            else if (branch)
                new_pc = pcbranch;
            else if (jump)
                new_pc = pcjump;
            else if (jr)
                new_pc = pcjr;
            else
                new_pc = seq_pc;

            @(negedge clk);
            compare("pc", pc, m_pc);
            compare("inst_addr", inst_addr, m_pc);
            compare("finish", 32'(finish), 32'(inst_data_ok && !m_conflict));
            compare("slot_hit", 32'(slot_hit), {30'd0, 1'b1, s0_en});
            compare("slot1.en", 32'(slot1.en), 32'd1);
            compare("slot0.en", 32'(slot0.en), 32'(s0_en));
            compare("slot1.pcplus4", slot1.pcplus4, m_pc + 32'd4);
            compare("slot0.pcplus4", slot0.pcplus4, m_pc + 32'd8);
            compare("slot1.exception_instr", 32'(slot1.exception_instr),
                32'(m_pc[1:0] != 2'b00));
            compare("slot0.exception_instr", 32'(slot0.exception_instr),
                32'(m_pc[1:0] != 2'b00));
            compare("slot1.pred.taken", 32'(slot1.pred.taken), 32'(p1.taken));
            compare("slot1.pred.destpc", slot1.pred.destpc, p1.destpc);
            compare("slot0.pred.taken", 32'(slot0.pred.taken), 32'(p0.taken && s0_en));
            compare("slot1.instr", slot1.instr, mem_word({m_pc[31:2], 2'b00}));
            if (s0_en)
            begin
                compare("slot0.instr", slot0.instr, mem_word({m_pc[31:2], 2'b00} + 32'd4));
                compare("slot0.pred.destpc", slot0.pred.destpc, p0.destpc);
            end

            // state after the coming edge
            if (flush)
                m_pc = '0;
            else if ((!stall && !m_conflict) || redirect)
            begin
                m_pc = new_pc;
                if (redirect)
                    m_last = '0;
                else
                    m_last = s0_en ? p0 : p1;
            end
            if (redirect)
                m_conflict = 1'b1;
            else if (inst_data_ok)
                m_conflict = 1'b0;
            if (upd_valid)
            begin
                m_valid[upd_pc[IDX_W+1:2]] = 1'b1;
                m_upd_pc[upd_pc[IDX_W+1:2]] = upd_pc;
                m_entry[upd_pc[IDX_W+1:2]] = {upd_taken, upd_target};
            end
            @(posedge clk);
            #2;
        end

        $display("%0d mismatches over %0d cycles", errors, RUN_CYCLES);
        if (errors == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
rtl/fetch_pkg.sv
rtl/fetch_redirect_select.sv
rtl/branch_predict_buffer.sv
rtl/fetch_unit.sv
rtl/fetch_top.sv
dv/fetch_assertions.sv
dv/fetch_tb.sv

/* Makefile */
TOP := fetch_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o vsim
	./obj_dir/vsim | tee /dev/stderr | grep -qx 'TB PASSED'

clean:
	rm -rf obj_dir
